// File: design/ebusPkg.sv
package ebusPkg;

  // One EBUS word keeps the full machine width
  localparam int ebusDataWidth = 36;

  typedef logic [ebusDataWidth-1:0] ebusData_t;

  // Device select codes driven on the EBUS control lines
  typedef logic [1:0] ebusDev_t;

  localparam ebusDev_t devApr  = 2'd0;
  localparam ebusDev_t devPi   = 2'd1;
  localparam ebusDev_t devMtr  = 2'd2;
  // No device answers to this code, so a read of it returns zero
  localparam ebusDev_t devNone = 2'd3;

  // EBUS function codes
  typedef logic [1:0] ebusFunc_t;

  localparam ebusFunc_t funcCondIn  = 2'd0;
  localparam ebusFunc_t funcDataIn  = 2'd1;
  localparam ebusFunc_t funcCondOut = 2'd2;
  localparam ebusFunc_t funcUnused  = 2'd3;

  // Interrupt level, 1 is the highest priority and 0 means none
  typedef logic [2:0] piLevel_t;

  // One bit per interrupt level, bit k stands for level k+1
  typedef logic [6:0] piMask_t;

  // APR error sources, one bit per sticky flag
  typedef logic [3:0] aprErr_t;

  // Host bridge sequencing
  typedef enum logic [1:0] {
    hostIdle,
    hostDemand,
    hostXfer
  } hostState_t;

endpackage

// File: design/aprDevice.sv
`timescale 1ns/1ps

module aprDevice import ebusPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  logic      ebusDemand,
  input  ebusDev_t  ebusDev,
  input  ebusFunc_t ebusFunc,
  input  ebusData_t ebusWrData,
  input  aprErr_t   errIn,
  output logic      driving,
  output ebusData_t data,
  output logic      aprReq,
  output piLevel_t  aprLevel
);

  aprErr_t  flags;
  aprErr_t  enables;
  piLevel_t level;

  logic      writeHit;
  logic      readHit;
  ebusData_t condWord;

  assign writeHit = ebusDemand && (ebusDev == devApr) && (ebusFunc == funcCondOut);
  assign readHit  = ebusDemand && (ebusDev == devApr) &&
                    ((ebusFunc == funcCondIn) || (ebusFunc == funcDataIn));

  // Sticky flags, write-one-to-clear. A new error pulse on the same
  // edge as a clear keeps its flag set
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags   <= '0;
      enables <= '0;
      level   <= '0;
    end else begin
      if (writeHit) begin
        flags   <= (flags & ~ebusWrData[3:0]) | errIn;
        enables <= ebusWrData[7:4];
        level   <= ebusWrData[10:8];
      end else begin
        flags <= flags | errIn;
      end
    end
  end

  // Condition word uses the same layout as a condOut write
  always_comb begin
    condWord       = '0;
    condWord[3:0]  = flags;
    condWord[7:4]  = enables;
    condWord[10:8] = level;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      driving <= 1'b0;
    end else begin
      driving <= readHit;
    end
  end

  // APR has no data register, so dataIn reads as zero
  always_ff @(posedge clk) begin
    if (readHit) begin
      data <= (ebusFunc == funcCondIn) ? condWord : '0;
    end
  end

  assign aprReq   = |(flags & enables);
  assign aprLevel = level;

endmodule

// File: design/piDevice.sv
`timescale 1ns/1ps

module piDevice import ebusPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  logic      ebusDemand,
  input  ebusDev_t  ebusDev,
  input  ebusFunc_t ebusFunc,
  input  ebusData_t ebusWrData,
  input  logic      aprReq,
  input  piLevel_t  aprLevel,
  output logic      driving,
  output ebusData_t data,
  output logic      piReq,
  output piLevel_t  piActiveLevel
);

  piMask_t swReq;
  piMask_t enables;
  logic    sysOn;

  // APR request steered onto its programmed level
  piMask_t aprVec;
  piMask_t pending;

  logic      writeHit;
  logic      readHit;
  ebusData_t condWord;

  // Level 1 sits in bit 0 and wins over everything above it
  function automatic piLevel_t lowestLevel(input piMask_t vec);
    piLevel_t lvl;
    lvl = '0;
    for (int k = 6; k >= 0; k--) begin
      if (vec[k]) begin
        lvl = piLevel_t'(k + 1);
      end
    end
    return lvl;
  endfunction

  assign writeHit = ebusDemand && (ebusDev == devPi) && (ebusFunc == funcCondOut);
  assign readHit  = ebusDemand && (ebusDev == devPi) &&
                    ((ebusFunc == funcCondIn) || (ebusFunc == funcDataIn));

  // Set bits take precedence when a level is both set and cleared
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      swReq   <= '0;
      enables <= '0;
      sysOn   <= 1'b0;
    end else if (writeHit) begin
      swReq   <= (swReq & ~ebusWrData[13:7]) | ebusWrData[6:0];
      enables <= ebusWrData[20:14];
      sysOn   <= ebusWrData[21];
    end
  end

  // A request at level 0 means the APR has no level programmed
  always_comb begin
    aprVec = '0;
    if (aprReq && (aprLevel != '0)) begin
      aprVec[aprLevel - 3'd1] = 1'b1;
    end
  end

  assign pending       = (swReq | aprVec) & enables;
  assign piActiveLevel = sysOn ? lowestLevel(pending) : '0;
  assign piReq         = (piActiveLevel != '0);

  // Pending replaces the set field, the clear field reads as zero
  always_comb begin
    condWord        = '0;
    condWord[6:0]   = pending;
    condWord[20:14] = enables;
    condWord[21]    = sysOn;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      driving <= 1'b0;
    end else begin
      driving <= readHit;
    end
  end

  always_ff @(posedge clk) begin
    if (readHit) begin
      data <= (ebusFunc == funcCondIn) ? condWord : '0;
    end
  end

endmodule

// File: design/mtrDevice.sv
`timescale 1ns/1ps

module mtrDevice import ebusPkg::*; #(
  parameter int timebaseWidth = 16
) (
  input  logic      clk,
  input  logic      arstN,
  input  logic      ebusDemand,
  input  ebusDev_t  ebusDev,
  input  ebusFunc_t ebusFunc,
  input  ebusData_t ebusWrData,
  output logic      driving,
  output ebusData_t data
);

  logic                     run;
  logic [timebaseWidth-1:0] count;

  logic      writeHit;
  logic      readHit;
  ebusData_t countWord;

  assign writeHit = ebusDemand && (ebusDev == devMtr) && (ebusFunc == funcCondOut);
  assign readHit  = ebusDemand && (ebusDev == devMtr) &&
                    ((ebusFunc == funcCondIn) || (ebusFunc == funcDataIn));

  // Clear beats counting on the edge of the write
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      run   <= 1'b0;
      count <= '0;
    end else begin
      if (writeHit) begin
        run <= ebusWrData[0];
      end
      if (writeHit && ebusWrData[1]) begin
        count <= '0;
      end else if (run) begin
        count <= count + 1'b1;
      end
    end
  end

  // Timebase zero-extended to a full EBUS word
  always_comb begin
    countWord                    = '0;
    countWord[timebaseWidth-1:0] = count;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      driving <= 1'b0;
    end else begin
      driving <= readHit;
    end
  end

  always_ff @(posedge clk) begin
    if (readHit) begin
      data <= (ebusFunc == funcDataIn) ? countWord : ebusData_t'(run);
    end
  end

endmodule

// File: design/ebusHost.sv
`timescale 1ns/1ps

module ebusHost import ebusPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  logic [3:0] adr,
  input  ebusData_t  datWr,
  input  ebusData_t  ebusRdData,
  output ebusData_t  datRd,
  output logic       ack,
  output logic       ebusDemand,
  output ebusDev_t   ebusDev,
  output ebusFunc_t  ebusFunc,
  output ebusData_t  ebusWrData
);

  hostState_t state;

  // A new Wishbone cycle is taken only while idle and not acknowledging
  logic      start;
  ebusFunc_t readFunc;

  assign start = (state == hostIdle) && cyc && stb && !ack;

  // A read that names condOut in its function bits must not turn into
  // a write on the EBUS, so it goes out as the unused code instead
  always_comb begin
    if (adr[1:0] == funcCondOut) begin
      readFunc = funcUnused;
    end else begin
      readFunc = adr[1:0];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state      <= hostIdle;
      ack        <= 1'b0;
      ebusDemand <= 1'b0;
      ebusDev    <= devNone;
      ebusFunc   <= funcUnused;
    end else begin
      ebusDemand <= 1'b0;
      ack        <= 1'b0;
      case (state)
        hostIdle: begin
          if (start) begin
            state      <= hostDemand;
            ebusDemand <= 1'b1;
            ebusDev    <= adr[3:2];
            // Every write is a condition-out transfer
            ebusFunc   <= we ? funcCondOut : readFunc;
          end
        end
        hostDemand: begin
          // The addressed device registers its answer on this edge
          state <= hostXfer;
        end
        hostXfer: begin
          state <= hostIdle;
          ack   <= 1'b1;
        end
        default: begin
          state <= hostIdle;
        end
      endcase
    end
  end

  // Write data is held for the whole transfer
  always_ff @(posedge clk) begin
    if (start) begin
      ebusWrData <= datWr;
    end
  end

  // The muxed EBUS word is valid in the cycle before ack rises
  always_ff @(posedge clk) begin
    if (state == hostXfer) begin
      datRd <= ebusRdData;
    end
  end

endmodule

// File: design/ebusTop.sv
`timescale 1ns/1ps

module ebusTop import ebusPkg::*; #(
  parameter int timebaseWidth = 16
) (
  input  logic       clk,
  input  logic       arstN,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  logic [3:0] adr,
  input  ebusData_t  datWr,
  output ebusData_t  datRd,
  output logic       ack,
  input  aprErr_t    errIn,
  output logic       piReq,
  output piLevel_t   piActiveLevel
);

  // EBUS control lines from the host bridge to every device
  logic      ebusDemand;
  ebusDev_t  ebusDev;
  ebusFunc_t ebusFunc;
  ebusData_t ebusWrData;

  // The multiplexed EBUS word going back to the host
  ebusData_t ebusRdData;

  logic      aprDriving;
  ebusData_t aprData;
  logic      piDriving;
  ebusData_t piData;
  logic      mtrDriving;
  ebusData_t mtrData;

  // Hardware interrupt request from the APR into the PI
  logic     aprReq;
  piLevel_t aprLevel;

  ebusHost host0 (
    .clk        (clk),
    .arstN      (arstN),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .datWr      (datWr),
    .ebusRdData (ebusRdData),
    .datRd      (datRd),
    .ack        (ack),
    .ebusDemand (ebusDemand),
    .ebusDev    (ebusDev),
    .ebusFunc   (ebusFunc),
    .ebusWrData (ebusWrData)
  );

  aprDevice apr0 (
    .clk        (clk),
    .arstN      (arstN),
    .ebusDemand (ebusDemand),
    .ebusDev    (ebusDev),
    .ebusFunc   (ebusFunc),
    .ebusWrData (ebusWrData),
    .errIn      (errIn),
    .driving    (aprDriving),
    .data       (aprData),
    .aprReq     (aprReq),
    .aprLevel   (aprLevel)
  );

  piDevice pi0 (
    .clk           (clk),
    .arstN         (arstN),
    .ebusDemand    (ebusDemand),
    .ebusDev       (ebusDev),
    .ebusFunc      (ebusFunc),
    .ebusWrData    (ebusWrData),
    .aprReq        (aprReq),
    .aprLevel      (aprLevel),
    .driving       (piDriving),
    .data          (piData),
    .piReq         (piReq),
    .piActiveLevel (piActiveLevel)
  );

  mtrDevice #(
    .timebaseWidth (timebaseWidth)
  ) mtr0 (
    .clk        (clk),
    .arstN      (arstN),
    .ebusDemand (ebusDemand),
    .ebusDev    (ebusDev),
    .ebusFunc   (ebusFunc),
    .ebusWrData (ebusWrData),
    .driving    (mtrDriving),
    .data       (mtrData)
  );

  // Only one device drives at a time in practice, but the order still
  // decides who wins if two ever answer the same demand
  always_comb begin
    if (aprDriving)      ebusRdData = aprData;
    else if (piDriving)  ebusRdData = piData;
    else if (mtrDriving) ebusRdData = mtrData;
    else                 ebusRdData = '0;
  end

endmodule

// File: verification/ebusTb.sv
`timescale 1ns/1ps

module ebusTb import ebusPkg::*; ();

  localparam int clkPeriod     = 40;
  localparam int resetCycles   = 16;
  // About 80 transfers are issued below and this rounds that up for margin
  localparam int plannedXfers  = 100;
  localparam int cyclesPerXfer = 200;

  logic       clk;
  logic       arstN;
  logic       cyc;
  logic       stb;
  logic       we;
  logic [3:0] adr;
  ebusData_t  datWr;
  ebusData_t  datRd;
  logic       ack;
  aprErr_t    errIn;
  logic       piReq;
  piLevel_t   piActiveLevel;

  // Reference model of the device registers
  aprErr_t  mFlags;
  aprErr_t  mAprEn;
  piLevel_t mAprLvl;
  piMask_t  mSw;
  piMask_t  mPiEn;
  logic     mSysOn;

  integer    seed = 15905;
  ebusData_t rd;
  ebusData_t rd2;
  logic [31:0] r;

  ebusTop #(
    .timebaseWidth (16)
  ) ebusTop_i (
    .clk           (clk),
    .arstN         (arstN),
    .cyc           (cyc),
    .stb           (stb),
    .we            (we),
    .adr           (adr),
    .datWr         (datWr),
    .datRd         (datRd),
    .ack           (ack),
    .errIn         (errIn),
    .piReq         (piReq),
    .piActiveLevel (piActiveLevel)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic stopOnError(input string msg);
    $display("Error: time %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Ack comes two edges after the edge that first sees the strobe
  ackLatency: assert property (@(posedge clk) disable iff (!arstN)
    $rose(ack) |-> ($past(cyc && stb, 1) && $past(cyc && stb, 2) &&
                    $past(cyc && stb, 3) && !$past(stb, 4)))
    else stopOnError("ack without a strobe sampled two edges earlier");

  stbToAck: assert property (@(posedge clk) disable iff (!arstN)
    ($past(stb, 3) && !$past(stb, 4)) |-> $rose(ack))
    else stopOnError("strobe was not acknowledged two edges later");

  ackPulse: assert property (@(posedge clk) disable iff (!arstN) ack |=> !ack)
    else stopOnError("ack lasted longer than one cycle");

  // Pending levels as the PI should see them with the APR request included
  function automatic piMask_t pendingMask();
    piMask_t vec;
    vec = mSw;
    if (((mFlags & mAprEn) != '0) && (mAprLvl != '0)) begin
      vec[mAprLvl - 3'd1] = 1'b1;
    end
    return vec & mPiEn;
  endfunction

  function automatic piLevel_t expectedLevel();
    piMask_t vec;
    vec = pendingMask();
    if (!mSysOn) return '0;
    for (int k = 0; k < 7; k++) begin
      if (vec[k]) return piLevel_t'(k + 1);
    end
    return '0;
  endfunction

  task automatic wbCycle(input logic isWrite, input ebusDev_t dev, input ebusFunc_t func,
                         input ebusData_t wdata, output ebusData_t rdata);
    @(posedge clk);
    #2;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = isWrite;
    adr   = {dev, func};
    datWr = wdata;
    do begin
      @(posedge clk);
      #1;
    end while (!ack);
    rdata = datRd;
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wbWrite(input ebusDev_t dev, input ebusData_t wdata);
    ebusData_t unused;
    wbCycle(1'b1, dev, funcCondOut, wdata, unused);
  endtask

  task automatic wbRead(input ebusDev_t dev, input ebusFunc_t func, output ebusData_t rdata);
    wbCycle(1'b0, dev, func, '0, rdata);
  endtask

  task automatic checkRead(input ebusDev_t dev, input ebusFunc_t func, input ebusData_t exp,
                           input string what);
    ebusData_t got;
    wbRead(dev, func, got);
    assert (got == exp)
      else stopOnError($sformatf("%s read %h, expected %h", what, got, exp));
  endtask

  task automatic checkInterrupt(input string what);
    piLevel_t lvl;
    lvl = expectedLevel();
    assert ((piActiveLevel == lvl) && (piReq == (lvl != '0)))
      else stopOnError($sformatf("%s active level %0d req %b, expected level %0d",
                                 what, piActiveLevel, piReq, lvl));
  endtask

  task automatic pulseErr(input aprErr_t e);
    @(posedge clk);
    #2;
    errIn = e;
    @(posedge clk);
    #2;
    errIn  = '0;
    mFlags = mFlags | e;
  endtask

  task automatic aprWrite(input aprErr_t clr, input aprErr_t en, input piLevel_t lvl);
    wbWrite(devApr, ebusData_t'({lvl, en, clr}));
    mFlags  = mFlags & ~clr;
    mAprEn  = en;
    mAprLvl = lvl;
  endtask

  task automatic piWrite(input piMask_t set, input piMask_t clr, input piMask_t en,
                         input logic on);
    wbWrite(devPi, ebusData_t'({on, en, clr, set}));
    mSw    = (mSw & ~clr) | set;
    mPiEn  = en;
    mSysOn = on;
  endtask

  function automatic ebusData_t aprWord();
    return ebusData_t'({mAprLvl, mAprEn, mFlags});
  endfunction

  function automatic ebusData_t piWord();
    return ebusData_t'({mSysOn, mPiEn, 7'd0, pendingMask()});
  endfunction

  initial begin
    repeat (resetCycles + cyclesPerXfer * plannedXfers) @(posedge clk);
    $display("Watchdog expired before the tests finished, the bus is probably stuck");
    $display("** FAIL **");
    $fatal(1, "Watchdog timeout");
  end

  initial begin
    arstN = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    datWr = '0;
    errIn = '0;
    {mFlags, mAprEn, mAprLvl, mSw, mPiEn, mSysOn} = '0;
    repeat (resetCycles) @(posedge clk);
    #2;
    arstN = 1'b1;

    // Everything reads as zero straight out of reset
    checkRead(devApr, funcCondIn, '0, "APR condIn after reset");
    checkRead(devPi, funcCondIn, '0, "PI condIn after reset");
    checkRead(devMtr, funcDataIn, '0, "MTR dataIn after reset");
    checkRead(devNone, funcCondIn, '0, "empty device condIn");
    checkRead(devNone, funcDataIn, '0, "empty device dataIn");
    checkInterrupt("after reset");

    // APR sticky flags with write-one-to-clear
    pulseErr(4'b1010);
    checkRead(devApr, funcCondIn, aprWord(), "APR flags set");
    aprWrite(4'b0010, 4'b0000, 3'd0);
    checkRead(devApr, funcCondIn, aprWord(), "APR single clear");
    pulseErr(4'b0101);
    aprWrite(4'b0001, 4'b1011, 3'd5);
    checkRead(devApr, funcCondIn, aprWord(), "APR enables and level");
    aprWrite(4'b1111, 4'b0000, 3'd0);
    checkRead(devApr, funcCondIn, aprWord(), "APR clear all");

    // Random PI patterns where the last few run with system-on dropped
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      piWrite(r[6:0], r[13:7], r[20:14], i < 18);
      checkInterrupt($sformatf("PI pattern %0d", i));
      checkRead(devPi, funcCondIn, piWord(), "PI condIn");
    end

    // APR error at level 3 beats a software request at level 6
    piWrite(7'b0100000, 7'b1011111, 7'b1111111, 1'b1);
    aprWrite(4'b0000, 4'b0100, 3'd3);
    checkInterrupt("APR enabled without error");
    pulseErr(4'b0100);
    checkInterrupt("APR error at level 3");
    checkRead(devPi, funcCondIn, piWord(), "PI with APR request");
    aprWrite(4'b0100, 4'b0100, 3'd3);
    checkInterrupt("APR error cleared");

    // Meter stopped, running, then cleared again
    wbWrite(devMtr, ebusData_t'(2'b10));
    checkRead(devMtr, funcDataIn, '0, "MTR cleared while stopped");
    checkRead(devMtr, funcDataIn, '0, "MTR still stopped");
    wbWrite(devMtr, ebusData_t'(2'b01));
    checkRead(devMtr, funcCondIn, ebusData_t'(1), "MTR run bit");
    wbRead(devMtr, funcDataIn, rd);
    repeat (10) @(posedge clk);
    wbRead(devMtr, funcDataIn, rd2);
    assert (rd2 > rd)
      else stopOnError($sformatf("MTR count %h did not pass earlier %h", rd2, rd));
    wbWrite(devMtr, ebusData_t'(2'b10));
    checkRead(devMtr, funcDataIn, '0, "MTR clear after running");
    checkRead(devMtr, funcCondIn, '0, "MTR run bit off");

    $display("** PASS **");
    $finish;
  end

endmodule

// File: build.f
design/ebusPkg.sv
design/aprDevice.sv
design/piDevice.sv
design/mtrDevice.sv
design/ebusHost.sv
design/ebusTop.sv
verification/ebusTb.sv

// File: Makefile
# Verilator build, run, lint and clean for the EBUS model

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ebusTb
FILELIST  = build.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# The run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
